/* rtl/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  // Machine word and register index
  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;

  //////////////////////////////////////////////////
  // Opcodes and function fields
  //////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 values shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7, plain and alternate (SUB, SRA)
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // Same 32 bits seen as R-type or I-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } i;
  } instr_u;

  // ALU operations, NOP for illegal instructions
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_NOP
  } alu_op_e;

endpackage

/* rtl/rv_register_file.sv */
module rv_register_file import rv_pipe_pkg::*; #(
  parameter int unsigned NUM_REGS = 32
) (
  input  logic      clk_i,
  input  logic      reset_i,
  // Read ports
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output xlen_t     rdata_a_o,
  output xlen_t     rdata_b_o,
  // Write port
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  xlen_t     wdata_i
);

  xlen_t regs_q [NUM_REGS];

  // Entry 0 is cleared here and never written afterwards
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0 && waddr_i < NUM_REGS) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads
  // x0 and indices past the array return zero
  assign rdata_a_o = (raddr_a_i == '0 || raddr_a_i >= NUM_REGS) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0 || raddr_b_i >= NUM_REGS) ? '0 : regs_q[raddr_b_i];

endmodule

/* rtl/rv_decode_stage.sv */
module rv_decode_stage import rv_pipe_pkg::*; #(
  parameter int unsigned NUM_REGS = 32
) (
  input  logic      clk_i,
  input  logic      reset_i,
  // Instruction stream
  input  logic      instr_valid_i,
  output logic      instr_ready_o,
  input  instr_u    instr_i,
  // Register file read
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  input  xlen_t     rf_rdata_a_i,
  input  xlen_t     rf_rdata_b_i,
  // Forward from execute
  input  logic      exe_fwd_valid_i,
  input  reg_addr_t exe_fwd_rd_i,
  input  xlen_t     exe_fwd_data_i,
  // Forward from writeback
  input  logic      wb_we_i,
  input  reg_addr_t wb_waddr_i,
  input  xlen_t     wb_wdata_i,
  // To execute
  output logic      dec_valid_o,
  input  logic      exe_ready_i,
  output xlen_t     op_a_o,
  output xlen_t     op_b_o,
  output reg_addr_t rd_o,
  output logic      rd_we_o,
  output logic      illegal_o,
  output alu_op_e   alu_op_o
);

  logic    dec_valid_q;
  instr_u  instr_q;
  logic    is_imm;
  logic    f7_alt_ok;
  logic    dec_illegal;
  alu_op_e dec_alu_op;
  xlen_t   imm_sext;
  xlen_t   rs1_val;
  xlen_t   rs2_val;

  // Operand select: x0, then execute, then writeback, then register file
  function automatic xlen_t fwd_sel(input reg_addr_t addr, input xlen_t rf_data);
    if (addr == '0) begin
      return '0;
    end else if (exe_fwd_valid_i && exe_fwd_rd_i == addr) begin
      return exe_fwd_data_i;
    end else if (wb_we_i && wb_waddr_i == addr) begin
      return wb_wdata_i;
    end
    return rf_data;
  endfunction

  //////////////////////////////////////////////////
  // Instruction buffer
  //////////////////////////////////////////////////

  // Free when empty or emptied this cycle
  assign instr_ready_o = !dec_valid_q || exe_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_valid_q <= 1'b0;
    end else if (instr_ready_o) begin
      dec_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      instr_q <= instr_i;
    end
  end

  //////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////

  assign imm_sext = {{20{instr_q.i.imm12[11]}}, instr_q.i.imm12};

  always_comb begin
    dec_alu_op  = ALU_NOP;
    dec_illegal = 1'b0;
    is_imm      = 1'b0;
    f7_alt_ok   = 1'b0;
    case (instr_q.r.opcode)
      OPC_OP: begin
        case (instr_q.r.funct3)
          F3_ADD_SUB: begin
            dec_alu_op = (instr_q.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
            f7_alt_ok  = 1'b1;
          end
          F3_SRL_SRA: begin
            dec_alu_op = (instr_q.r.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            f7_alt_ok  = 1'b1;
          end
          F3_SLL:  dec_alu_op = ALU_SLL;
          F3_SLT:  dec_alu_op = ALU_SLT;
          F3_XOR:  dec_alu_op = ALU_XOR;
          F3_OR:   dec_alu_op = ALU_OR;
          F3_AND:  dec_alu_op = ALU_AND;
          default: dec_illegal = 1'b1;
        endcase
        // Only ADD/SUB and SRL/SRA accept the alternate funct7
        if (!(instr_q.r.funct7 == F7_BASE || (f7_alt_ok && instr_q.r.funct7 == F7_ALT))) begin
          dec_illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        is_imm = 1'b1;
        case (instr_q.i.funct3)
          F3_ADD_SUB: dec_alu_op = ALU_ADD;
          F3_SLT:     dec_alu_op = ALU_SLT;
          F3_XOR:     dec_alu_op = ALU_XOR;
          F3_OR:      dec_alu_op = ALU_OR;
          F3_AND:     dec_alu_op = ALU_AND;
          // Immediate shifts are not supported
          default:    dec_illegal = 1'b1;
        endcase
      end
      default: dec_illegal = 1'b1;
    endcase
    // Register indices beyond the implemented file
    if (instr_q.r.rd >= NUM_REGS || instr_q.r.rs1 >= NUM_REGS) begin
      dec_illegal = 1'b1;
    end
    if (!is_imm && instr_q.r.rs2 >= NUM_REGS) begin
      dec_illegal = 1'b1;
    end
    if (dec_illegal) begin
      dec_alu_op = ALU_NOP;
    end
  end

  //////////////////////////////////////////////////
  // Operands
  //////////////////////////////////////////////////

  assign rf_raddr_a_o = instr_q.r.rs1;
  assign rf_raddr_b_o = instr_q.r.rs2;

  // Re-evaluated every cycle while waiting on execute
  always_comb begin
    rs1_val = fwd_sel(instr_q.r.rs1, rf_rdata_a_i);
    rs2_val = fwd_sel(instr_q.r.rs2, rf_rdata_b_i);
  end

  assign dec_valid_o = dec_valid_q;
  assign op_a_o      = rs1_val;
  assign op_b_o      = is_imm ? imm_sext : rs2_val;
  assign rd_o        = instr_q.r.rd;
  assign rd_we_o     = !dec_illegal;
  assign illegal_o   = dec_illegal;
  assign alu_op_o    = dec_alu_op;

endmodule

/* rtl/rv_execute_stage.sv */
module rv_execute_stage import rv_pipe_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // From decode
  input  logic      dec_valid_i,
  output logic      exe_ready_o,
  input  xlen_t     op_a_i,
  input  xlen_t     op_b_i,
  input  reg_addr_t rd_i,
  input  logic      rd_we_i,
  input  logic      illegal_i,
  input  alu_op_e   alu_op_i,
  // Forward to decode
  output logic      exe_fwd_valid_o,
  output reg_addr_t exe_fwd_rd_o,
  output xlen_t     exe_fwd_data_o,
  // To writeback
  output logic      exe_valid_o,
  input  logic      wb_ready_i,
  output xlen_t     result_o,
  output reg_addr_t rd_o,
  output logic      rd_we_o,
  output logic      illegal_o
);

  logic      exe_valid_q;
  xlen_t     op_a_q;
  xlen_t     op_b_q;
  reg_addr_t rd_q;
  logic      rd_we_q;
  logic      illegal_q;
  alu_op_e   alu_op_q;
  logic [4:0] shamt;
  xlen_t     alu_result;

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////

  // Accept only while writeback can drain
  // A result held in writeback is visible to decode only on its retire,
  // so an operand must not leave decode past a stalled writeback
  assign exe_ready_o = wb_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_valid_q <= 1'b0;
    end else if (exe_ready_o) begin
      exe_valid_q <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i && exe_ready_o) begin
      op_a_q    <= op_a_i;
      op_b_q    <= op_b_i;
      rd_q      <= rd_i;
      rd_we_q   <= rd_we_i;
      illegal_q <= illegal_i;
      alu_op_q  <= alu_op_i;
    end
  end

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  // Shift amount from the low bits of b
  assign shamt = op_b_q[4:0];

  always_comb begin
    case (alu_op_q)
      ALU_ADD: alu_result = op_a_q + op_b_q;
      ALU_SUB: alu_result = op_a_q - op_b_q;
      ALU_AND: alu_result = op_a_q & op_b_q;
      ALU_OR:  alu_result = op_a_q | op_b_q;
      ALU_XOR: alu_result = op_a_q ^ op_b_q;
      ALU_SLL: alu_result = op_a_q << shamt;
      ALU_SRL: alu_result = op_a_q >> shamt;
      ALU_SRA: alu_result = xlen_t'($signed(op_a_q) >>> shamt);
      // Signed compare, result in bit 0
      ALU_SLT: alu_result = {31'b0, $signed(op_a_q) < $signed(op_b_q)};
      default: alu_result = '0;
    endcase
  end

  // Forward while a writing instruction sits here
  assign exe_fwd_valid_o = exe_valid_q && rd_we_q;
  assign exe_fwd_rd_o    = rd_q;
  assign exe_fwd_data_o  = alu_result;

  assign exe_valid_o = exe_valid_q;
  assign result_o    = alu_result;
  assign rd_o        = rd_q;
  assign rd_we_o     = rd_we_q;
  assign illegal_o   = illegal_q;

endmodule

/* rtl/rv_writeback_stage.sv */
module rv_writeback_stage import rv_pipe_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // From execute
  input  logic      exe_valid_i,
  output logic      wb_ready_o,
  input  xlen_t     result_i,
  input  reg_addr_t rd_i,
  input  logic      rd_we_i,
  input  logic      illegal_i,
  // Retire stream
  output logic      retire_valid_o,
  input  logic      retire_ready_i,
  output reg_addr_t retire_rd_o,
  output xlen_t     retire_result_o,
  output logic      retire_illegal_o,
  // Register file write, also forwarded to decode
  output logic      rf_we_o,
  output reg_addr_t rf_waddr_o,
  output xlen_t     rf_wdata_o
);

  logic      wb_valid_q;
  xlen_t     result_q;
  reg_addr_t rd_q;
  logic      rd_we_q;
  logic      illegal_q;
  logic      retire_fire;

  // EX/WB register
  assign wb_ready_o = !wb_valid_q || retire_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_q <= 1'b0;
    end else if (wb_ready_o) begin
      wb_valid_q <= exe_valid_i;
    end
  end

  // Payload holds while the retire stream stalls
  always_ff @(posedge clk_i) begin
    if (exe_valid_i && wb_ready_o) begin
      result_q  <= result_i;
      rd_q      <= rd_i;
      rd_we_q   <= rd_we_i;
      illegal_q <= illegal_i;
    end
  end

  assign retire_fire      = wb_valid_q && retire_ready_i;
  assign retire_valid_o   = wb_valid_q;
  assign retire_rd_o      = rd_q;
  assign retire_result_o  = result_q;
  assign retire_illegal_o = illegal_q;

  // Write on retire only, legal and not x0
  assign rf_we_o    = retire_fire && rd_we_q && !illegal_q && rd_q != '0;
  assign rf_waddr_o = rd_q;
  assign rf_wdata_o = result_q;

endmodule

/* rtl/rv_core_top.sv */
module rv_core_top import rv_pipe_pkg::*; #(
  parameter int unsigned NUM_REGS = 32
) (
  input  logic      clk_i,
  input  logic      reset_i,
  // Instruction stream
  input  logic      instr_valid_i,
  output logic      instr_ready_o,
  input  instr_u    instr_i,
  // Retire stream
  output logic      retire_valid_o,
  input  logic      retire_ready_i,
  output reg_addr_t retire_rd_o,
  output xlen_t     retire_result_o,
  output logic      retire_illegal_o
);

  // Register file read
  reg_addr_t rf_raddr_a;
  reg_addr_t rf_raddr_b;
  xlen_t     rf_rdata_a;
  xlen_t     rf_rdata_b;

  // Register file write, from writeback
  logic      rf_we;
  reg_addr_t rf_waddr;
  xlen_t     rf_wdata;

  // Execute forward
  logic      exe_fwd_valid;
  reg_addr_t exe_fwd_rd;
  xlen_t     exe_fwd_data;

  // Decode to execute
  logic      dec_valid;
  logic      exe_ready;
  xlen_t     dec_op_a;
  xlen_t     dec_op_b;
  reg_addr_t dec_rd;
  logic      dec_rd_we;
  logic      dec_illegal;
  alu_op_e   dec_alu_op;

  // Execute to writeback
  logic      exe_valid;
  logic      wb_ready;
  xlen_t     exe_result;
  reg_addr_t exe_rd;
  logic      exe_rd_we;
  logic      exe_illegal;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  rv_decode_stage #(
    .NUM_REGS        (NUM_REGS)
  ) id_stage_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .instr_valid_i   (instr_valid_i),
    .instr_ready_o   (instr_ready_o),
    .instr_i         (instr_i),
    .rf_raddr_a_o    (rf_raddr_a),
    .rf_raddr_b_o    (rf_raddr_b),
    .rf_rdata_a_i    (rf_rdata_a),
    .rf_rdata_b_i    (rf_rdata_b),
    .exe_fwd_valid_i (exe_fwd_valid),
    .exe_fwd_rd_i    (exe_fwd_rd),
    .exe_fwd_data_i  (exe_fwd_data),
    .wb_we_i         (rf_we),
    .wb_waddr_i      (rf_waddr),
    .wb_wdata_i      (rf_wdata),
    .dec_valid_o     (dec_valid),
    .exe_ready_i     (exe_ready),
    .op_a_o          (dec_op_a),
    .op_b_o          (dec_op_b),
    .rd_o            (dec_rd),
    .rd_we_o         (dec_rd_we),
    .illegal_o       (dec_illegal),
    .alu_op_o        (dec_alu_op)
  );

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////

  rv_execute_stage ex_stage_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .dec_valid_i     (dec_valid),
    .exe_ready_o     (exe_ready),
    .op_a_i          (dec_op_a),
    .op_b_i          (dec_op_b),
    .rd_i            (dec_rd),
    .rd_we_i         (dec_rd_we),
    .illegal_i       (dec_illegal),
    .alu_op_i        (dec_alu_op),
    .exe_fwd_valid_o (exe_fwd_valid),
    .exe_fwd_rd_o    (exe_fwd_rd),
    .exe_fwd_data_o  (exe_fwd_data),
    .exe_valid_o     (exe_valid),
    .wb_ready_i      (wb_ready),
    .result_o        (exe_result),
    .rd_o            (exe_rd),
    .rd_we_o         (exe_rd_we),
    .illegal_o       (exe_illegal)
  );

  //////////////////////////////////////////////////
  // Writeback
  //////////////////////////////////////////////////

  rv_writeback_stage wb_stage_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .exe_valid_i      (exe_valid),
    .wb_ready_o       (wb_ready),
    .result_i         (exe_result),
    .rd_i             (exe_rd),
    .rd_we_i          (exe_rd_we),
    .illegal_i        (exe_illegal),
    .retire_valid_o   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_rd_o      (retire_rd_o),
    .retire_result_o  (retire_result_o),
    .retire_illegal_o (retire_illegal_o),
    .rf_we_o          (rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata)
  );

  // Register file, read by decode, written by writeback
  rv_register_file #(
    .NUM_REGS  (NUM_REGS)
  ) register_file_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

endmodule

/* tests/tb_checker.sv */
module tb_checker import rv_pipe_pkg::*; #(
  parameter int unsigned NUM_REGS = 32
) (
  input  logic      clk_i,
  input  logic      reset_i,
  // Instruction stream as seen at the DUT
  input  logic      instr_valid_i,
  input  logic      instr_ready_i,
  input  xlen_t     instr_i,
  // Retire stream as seen at the DUT
  input  logic      retire_valid_i,
  input  logic      retire_ready_i,
  input  reg_addr_t retire_rd_i,
  input  xlen_t     retire_result_i,
  input  logic      retire_illegal_i,
  // Running counts for the test sequencer
  output int        error_count_o,
  output int        retire_count_o,
  output int        pending_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Name of the running test, set by tb_top
  string     test_name = "none";

  xlen_t     ref_regs [32];
  reg_addr_t exp_rd_q [$];
  xlen_t     exp_result_q [$];
  logic      exp_illegal_q [$];
  logic      reset_q;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Executes one word against ref_regs, returns the illegal flag
  function automatic logic ref_exec(input xlen_t w, output xlen_t res);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      a;
    xlen_t      b;
    logic [4:0] sh;
    logic       bad;
    opcode = w[6:0];
    f3     = w[14:12];
    f7     = w[31:25];
    a      = ref_regs[w[19:15]];
    b      = ref_regs[w[24:20]];
    bad    = (w[11:7] >= NUM_REGS) || (w[19:15] >= NUM_REGS);
    if (opcode == OPC_OP_IMM) begin
      b = {{20{w[31]}}, w[31:20]};
      // No immediate shifts, no SLTIU
      if (f3 == F3_SLL || f3 == F3_SRL_SRA || f3 == 3'b011) begin
        bad = 1'b1;
      end
    end else if (opcode == OPC_OP) begin
      if (w[24:20] >= NUM_REGS || f3 == 3'b011) begin
        bad = 1'b1;
      end
      // Alternate funct7 only for SUB and SRA
      if (!(f7 == F7_BASE || (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)))) begin
        bad = 1'b1;
      end
    end else begin
      bad = 1'b1;
    end
    sh = b[4:0];
    case (f3)
      F3_ADD_SUB: res = (opcode == OPC_OP && f7 == F7_ALT) ? a - b : a + b;
      F3_SLL:     res = a << sh;
      // Signs differ means a is less exactly when a is negative
      F3_SLT:     res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      F3_XOR:     res = a ^ b;
      F3_SRL_SRA: res = (a >> sh) | ((f7 == F7_ALT && a[31]) ? ~(32'hffff_ffff >> sh) : '0);
      F3_OR:      res = a | b;
      F3_AND:     res = a & b;
      default:    res = '0;
    endcase
    return bad;
  endfunction

  //////////////////////////////////////////////////
  // Issue tracking and retire comparison
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : monitor
    xlen_t     res;
    logic      ill;
    reg_addr_t exp_rd;
    xlen_t     exp_res;
    logic      exp_ill;
    reset_q <= reset_i;
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
      end
      exp_rd_q.delete();
      exp_result_q.delete();
      exp_illegal_q.delete();
      error_count_o  = 0;
      retire_count_o = 0;
    end else begin
      // First edge out of reset
      if (reset_q === 1'b1) begin
        if (retire_valid_i !== 1'b0) begin
          $display("error %0s: retire_valid_o expected 0 actual %0b", test_name, retire_valid_i);
          error_count_o++;
        end
        if (instr_ready_i !== 1'b1) begin
          $display("error %0s: instr_ready_o expected 1 actual %0b", test_name, instr_ready_i);
          error_count_o++;
        end
      end
      if (retire_valid_i && retire_ready_i) begin
        if (exp_rd_q.size() == 0) begin
          $display("%0s: the DUT retired an instruction that was never issued", test_name);
          error_count_o++;
        end else begin
          exp_rd  = exp_rd_q.pop_front();
          exp_res = exp_result_q.pop_front();
          exp_ill = exp_illegal_q.pop_front();
          if (retire_illegal_i !== exp_ill) begin
            $display("error %0s: illegal expected %0b actual %0b",
                     test_name, exp_ill, retire_illegal_i);
            error_count_o++;
          end
          if (retire_rd_i !== exp_rd) begin
            $display("error %0s: rd expected %0d actual %0d", test_name, exp_rd, retire_rd_i);
            error_count_o++;
          end
          // Result of an illegal instruction is unspecified
          if (!exp_ill && retire_result_i !== exp_res) begin
            $display("error %0s: result expected 0x%08h actual 0x%08h",
                     test_name, exp_res, retire_result_i);
            error_count_o++;
          end
          retire_count_o++;
        end
      end
      // Writes land in issue order, x0 stays zero
      if (instr_valid_i && instr_ready_i) begin
        ill = ref_exec(instr_i, res);
        exp_rd_q.push_back(instr_i[11:7]);
        exp_result_q.push_back(res);
        exp_illegal_q.push_back(ill);
        if (!ill && instr_i[11:7] != 5'd0) begin
          ref_regs[instr_i[11:7]] = res;
        end
      end
    end
    pending_o = exp_rd_q.size();
  end

endmodule

/* tests/tb_top.sv */
module tb_top import rv_pipe_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_REGS   = 32;
  localparam int WAIT_LIMIT = 200;

  // Instruction mixes
  localparam int MIX_INDEP   = 0;
  localparam int MIX_DEP     = 1;
  localparam int MIX_ILLEGAL = 2;
  localparam int MIX_X0      = 3;

  logic      clk = 1'b0;
  logic      reset;
  logic      instr_valid;
  logic      instr_ready;
  instr_u    instr;
  logic      retire_valid;
  logic      retire_ready;
  reg_addr_t retire_rd;
  xlen_t     retire_result;
  logic      retire_illegal;

  integer    seed;
  int        ready_pct;
  reg_addr_t prev_rd [2];
  int        error_count;
  int        retire_count;
  int        pending;
  int        tests_run;
  int        tests_failed;

  always #4 clk = ~clk;

  rv_core_top #(
    .NUM_REGS         (NUM_REGS)
  ) uut (
    .clk_i            (clk),
    .reset_i          (reset),
    .instr_valid_i    (instr_valid),
    .instr_ready_o    (instr_ready),
    .instr_i          (instr),
    .retire_valid_o   (retire_valid),
    .retire_ready_i   (retire_ready),
    .retire_rd_o      (retire_rd),
    .retire_result_o  (retire_result),
    .retire_illegal_o (retire_illegal)
  );

  tb_checker #(
    .NUM_REGS         (NUM_REGS)
  ) check_i (
    .clk_i            (clk),
    .reset_i          (reset),
    .instr_valid_i    (instr_valid),
    .instr_ready_i    (instr_ready),
    .instr_i          (instr),
    .retire_valid_i   (retire_valid),
    .retire_ready_i   (retire_ready),
    .retire_rd_i      (retire_rd),
    .retire_result_i  (retire_result),
    .retire_illegal_i (retire_illegal),
    .error_count_o    (error_count),
    .retire_count_o   (retire_count),
    .pending_o        (pending)
  );

  //////////////////////////////////////////////////
  // Instruction generators
  //////////////////////////////////////////////////

  function automatic reg_addr_t rand_reg();
    return reg_addr_t'($unsigned($random(seed)) % NUM_REGS);
  endfunction

  // Never x0
  function automatic reg_addr_t rand_rd();
    return reg_addr_t'(1 + $unsigned($random(seed)) % (NUM_REGS - 1));
  endfunction

  // Mostly the rd of one of the last two instructions
  function automatic reg_addr_t dep_reg();
    int pick;
    pick = $unsigned($random(seed)) % 5;
    if (pick < 2) begin
      return prev_rd[0];
    end else if (pick < 4) begin
      return prev_rd[1];
    end
    return rand_reg();
  endfunction

  // One of the nine R-type or five I-type ops
  function automatic instr_u legal_op(input reg_addr_t rd, input reg_addr_t rs1,
                                      input reg_addr_t rs2);
    instr_u      w;
    int          sel;
    logic [2:0]  f3;
    logic [31:0] r;
    sel = $unsigned($random(seed)) % 14;
    r   = $random(seed);
    case (sel)
      0, 1, 9: f3 = F3_ADD_SUB;
      2:       f3 = F3_SLL;
      3, 10:   f3 = F3_SLT;
      4, 11:   f3 = F3_XOR;
      5, 6:    f3 = F3_SRL_SRA;
      7, 12:   f3 = F3_OR;
      default: f3 = F3_AND;
    endcase
    w          = '0;
    w.r.rd     = rd;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    if (sel < 9) begin
      w.r.opcode = OPC_OP;
      w.r.rs2    = rs2;
      w.r.funct7 = (sel == 1 || sel == 6) ? F7_ALT : F7_BASE;
    end else begin
      w.i.opcode = OPC_OP_IMM;
      w.i.imm12  = r[11:0];
    end
    return w;
  endfunction

  // Bad opcode, bad funct7, SLTU, or an immediate shift
  function automatic instr_u illegal_op(input reg_addr_t rd);
    instr_u      w;
    logic [31:0] r;
    int          kind;
    r      = $random(seed);
    kind   = $unsigned($random(seed)) % 4;
    w      = r;
    w.r.rd = rd;
    case (kind)
      0: w.r.opcode = {1'b1, r[5:0]};
      1: begin
        w.r.opcode = OPC_OP;
        w.r.funct7 = {1'b1, r[30:25]};
      end
      2: begin
        w.r.opcode = OPC_OP;
        w.r.funct3 = 3'b011;
        w.r.funct7 = F7_BASE;
      end
      default: begin
        w.i.opcode = OPC_OP_IMM;
        w.i.funct3 = r[30] ? 3'b011 : {r[31], 2'b01};
      end
    endcase
    return w;
  endfunction

  // ADDI rd, src, 0
  function automatic instr_u copy_op(input reg_addr_t rd, input reg_addr_t src);
    instr_u w;
    w          = '0;
    w.i.opcode = OPC_OP_IMM;
    w.i.funct3 = F3_ADD_SUB;
    w.i.rd     = rd;
    w.i.rs1    = src;
    return w;
  endfunction

  //////////////////////////////////////////////////
  // Stream drivers
  //////////////////////////////////////////////////

  task automatic drive_ready();
    retire_ready = ($unsigned($random(seed)) % 100) < ready_pct;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout: %0s did not complete within %0d cycles", what, WAIT_LIMIT);
    $display("Test failures found");
    $finish;
  endtask

  // Hold valid until the DUT takes the word
  task automatic send_instr(input instr_u word);
    int   waited;
    logic taken;
    instr_valid = 1'b1;
    instr       = word;
    waited      = 0;
    taken       = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = instr_ready;
      #1;
      drive_ready();
      waited++;
      if (!taken && waited >= WAIT_LIMIT) begin
        abort_on_timeout("instruction handshake");
      end
    end
    instr_valid = 1'b0;
    prev_rd[1]  = prev_rd[0];
    prev_rd[0]  = word.r.rd;
  endtask

  // Until every issued instruction has retired
  task automatic drain();
    int waited;
    waited = 0;
    while (pending != 0) begin
      @(posedge clk);
      #1;
      drive_ready();
      waited++;
      if (waited >= WAIT_LIMIT) begin
        abort_on_timeout("pipeline drain");
      end
    end
  endtask

  task automatic report_test(input string name, input int err_before, input int ret_before);
    int errs;
    errs = error_count - err_before;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %0s: %0d retired, %0d errors, %0s", name, retire_count - ret_before,
             errs, (errs == 0) ? "ok" : "FAILED");
  endtask

  task automatic run_test(input string name, input int mix, input int count, input int pct);
    int        err_before;
    int        ret_before;
    reg_addr_t target;
    check_i.test_name = name;
    ready_pct  = pct;
    err_before = error_count;
    ret_before = retire_count;
    for (int n = 0; n < count; n++) begin
      case (mix)
        MIX_INDEP: send_instr(legal_op(rand_rd(), rand_reg(), rand_reg()));
        MIX_DEP:   send_instr(legal_op(rand_rd(), dep_reg(), dep_reg()));
        MIX_ILLEGAL: begin
          target = rand_rd();
          // Illegal write, then read the old value back
          if ($unsigned($random(seed)) % 3 == 0) begin
            send_instr(illegal_op(target));
            send_instr(copy_op(rand_rd(), target));
          end else begin
            send_instr(legal_op(target, dep_reg(), dep_reg()));
          end
        end
        default: begin
          send_instr(legal_op(5'd0, rand_reg(), rand_reg()));
          send_instr(legal_op(rand_rd(), 5'd0, dep_reg()));
        end
      endcase
    end
    drain();
    report_test(name, err_before, ret_before);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    seed         = 75062;
    reset        = 1'b1;
    instr_valid  = 1'b0;
    instr        = '0;
    retire_ready = 1'b0;
    ready_pct    = 100;
    prev_rd[0]   = '0;
    prev_rd[1]   = '0;
    tests_run    = 0;
    tests_failed = 0;
    check_i.test_name = "reset_state";
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    drive_ready();
    // Checker samples the reset state at this edge
    @(posedge clk);
    #1;
    report_test("reset_state", 0, 0);

    run_test("alu_indep", MIX_INDEP, 200, 100);
    run_test("dep_chain", MIX_DEP, 200, 100);
    run_test("back_pressure", MIX_DEP, 300, 50);
    run_test("illegal", MIX_ILLEGAL, 150, 70);
    run_test("x0_writes", MIX_X0, 100, 100);

    $display("%0d tests, %0d failed, %0d retires checked, %0d errors",
             tests_run, tests_failed, retire_count, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* all.f */
rtl/rv_pipe_pkg.sv
rtl/rv_register_file.sv
rtl/rv_decode_stage.sv
rtl/rv_execute_stage.sv
rtl/rv_writeback_stage.sv
rtl/rv_core_top.sv
tests/tb_checker.sv
tests/tb_top.sv

/* Bender.yml */
package:
  name: rv_pipe

sources:
  - rtl/rv_pipe_pkg.sv
  - rtl/rv_register_file.sv
  - rtl/rv_decode_stage.sv
  - rtl/rv_execute_stage.sv
  - rtl/rv_writeback_stage.sv
  - rtl/rv_core_top.sv
  - target: test
    files:
      - tests/tb_checker.sv
      - tests/tb_top.sv
